/* source/periph_pkg.sv */
// --------------------------------------------------------------------------
// Address map, register offsets and sizes of the peripheral subsystem
// Only address bits 15..12 select a region, higher bits are ignored
// Region 0 holds the timer, region 1 the interrupt controller
// --------------------------------------------------------------------------
package periph_pkg;

    // Bus
    localparam int AddrWidth   = 32;
    localparam int DataWidth   = 32;
    localparam int OffsetWidth = 8;

    // Region map
    localparam int RegionLsb   = 12;
    localparam int RegionWidth = 4;
    localparam int RegionTimer = 0;
    localparam int RegionIrq   = 1;

    localparam logic [DataWidth-1:0] ErrReadData = 32'hDEADBEEF;

    // ------------------------------------------------------------------------
    // Timer
    // ------------------------------------------------------------------------
    localparam int NumTimers       = 2;
    localparam int TimerStride     = 'h10;
    localparam int TimerCntOffset  = 'h0;
    localparam int TimerCmpOffset  = 'h4;
    localparam int TimerCtrlOffset = 'h8;

    // Control register bits, the flag is read only
    localparam int CtrlEnableBit = 0;
    localparam int CtrlReloadBit = 1;
    localparam int CtrlFlagBit   = 31;

    // ------------------------------------------------------------------------
    // Interrupt controller
    // ------------------------------------------------------------------------
    localparam int NumExtIrq   = 2;
    localparam int NumSources  = NumTimers + NumExtIrq;
    localparam int PrioWidth   = 3;
    localparam int MaxPriority = 7;
    // Claim ID is source number plus one, zero means none
    localparam int SrcIdWidth  = 3;

    localparam int PrioBaseOffset  = 'h00;
    localparam int EnableOffset    = 'h10;
    localparam int ThresholdOffset = 'h14;
    localparam int ClaimOffset     = 'h18;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_RESP
    } access_state_e;

    typedef enum logic [1:0] {
        REGION_TIMER,
        REGION_IRQ,
        REGION_EMPTY
    } region_e;

endpackage

/* source/apb_access_fsm.sv */
// --------------------------------------------------------------------------
// Sequences one APB access at a time, no wait states from the devices
// The master must hold its request until pready_o is seen high
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module apb_access_fsm (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             psel_i,
    input  logic                             penable_i,
    input  logic                             pwrite_i,
    input  logic [periph_pkg::DataWidth-1:0] rdata_i,
    input  logic                             err_i,
    output logic                             wr_stb_o,
    output logic                             rd_stb_o,
    output logic [periph_pkg::DataWidth-1:0] prdata_o,
    output logic                             pready_o,
    output logic                             pslverr_o
);
    import periph_pkg::*;

    access_state_e state_q, state_d;
    logic          access;

    // Access phase seen, one cycle pulse since the state leaves ST_SETUP
    assign access   = (state_q == ST_SETUP) && psel_i && penable_i;
    assign wr_stb_o = access && pwrite_i;
    assign rd_stb_o = access && !pwrite_i;
    assign pready_o = (state_q == ST_RESP);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (psel_i) begin
                    state_d = ST_SETUP;
                end
            end
            ST_SETUP: begin
                if (access) begin
                    state_d = ST_RESP;
                end else if (!psel_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_RESP: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            pslverr_o <= 1'b0;
        end else begin
            state_q <= state_d;
            if (access) begin
                pslverr_o <= err_i;
            end else if (pready_o) begin
                pslverr_o <= 1'b0;
            end
        end
    end

    // Read data captured together with the error bit
    always_ff @(posedge clk_i) begin
        if (access) begin
            prdata_o <= rdata_i;
        end
    end

endmodule

/* source/periph_decode.sv */
// --------------------------------------------------------------------------
// Region decoder and read mux, empty regions act as an error slave
// Empty regions answer with an error and DEADBEEF, and see no strobe
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module periph_decode (
    input  logic [periph_pkg::AddrWidth-1:0]   paddr_i,
    input  logic [periph_pkg::DataWidth-1:0]   pwdata_i,
    input  logic                               wr_stb_i,
    input  logic                               rd_stb_i,
    input  logic [periph_pkg::DataWidth-1:0]   timer_rdata_i,
    input  logic [periph_pkg::DataWidth-1:0]   irq_rdata_i,
    output logic [periph_pkg::OffsetWidth-1:0] offset_o,
    output logic [periph_pkg::DataWidth-1:0]   wdata_o,
    output logic                               timer_wr_o,
    output logic                               timer_rd_o,
    output logic                               irq_wr_o,
    output logic                               irq_rd_o,
    output logic [periph_pkg::DataWidth-1:0]   rdata_o,
    output logic                               err_o
);
    import periph_pkg::*;

    region_e region;

    always_comb begin
        case (paddr_i[RegionLsb +: RegionWidth])
            RegionWidth'(RegionTimer): region = REGION_TIMER;
            RegionWidth'(RegionIrq):   region = REGION_IRQ;
            default:                   region = REGION_EMPTY;
        endcase
    end

    assign offset_o = paddr_i[OffsetWidth-1:0];
    assign wdata_o  = pwdata_i;

    // Strobes only reach the addressed device
    assign timer_wr_o = wr_stb_i && (region == REGION_TIMER);
    assign timer_rd_o = rd_stb_i && (region == REGION_TIMER);
    assign irq_wr_o   = wr_stb_i && (region == REGION_IRQ);
    assign irq_rd_o   = rd_stb_i && (region == REGION_IRQ);

    always_comb begin
        case (region)
            REGION_TIMER: rdata_o = timer_rdata_i;
            REGION_IRQ:   rdata_o = irq_rdata_i;
            default:      rdata_o = ErrReadData;
        endcase
    end

    assign err_o = (region == REGION_EMPTY);

endmodule

/* source/periph_timer.sv */
// --------------------------------------------------------------------------
// Two compare timers, each with CNT, CMP and CTRL at a 0x10 stride
// Only an enabled channel counts and matches
// Any CTRL write clears the sticky flag of that channel
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module periph_timer (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               wr_i,
    input  logic                               rd_i,
    input  logic [periph_pkg::OffsetWidth-1:0] offset_i,
    input  logic [periph_pkg::DataWidth-1:0]   wdata_i,
    output logic [periph_pkg::DataWidth-1:0]   rdata_o,
    output logic [periph_pkg::NumTimers-1:0]   flags_o
);
    import periph_pkg::*;

    logic [DataWidth-1:0] cnt_q [NumTimers];
    logic [DataWidth-1:0] cmp_q [NumTimers];
    logic [NumTimers-1:0] enable_q;
    logic [NumTimers-1:0] reload_q;
    logic [NumTimers-1:0] flag_q;

    logic [NumTimers-1:0] cnt_sel;
    logic [NumTimers-1:0] cmp_sel;
    logic [NumTimers-1:0] ctrl_sel;
    logic [NumTimers-1:0] match;

    // Register select per channel
    always_comb begin
        for (int c = 0; c < NumTimers; c++) begin
            cnt_sel[c]  = offset_i == OffsetWidth'(c * TimerStride + TimerCntOffset);
            cmp_sel[c]  = offset_i == OffsetWidth'(c * TimerStride + TimerCmpOffset);
            ctrl_sel[c] = offset_i == OffsetWidth'(c * TimerStride + TimerCtrlOffset);
            match[c]    = enable_q[c] && (cnt_q[c] == cmp_q[c]);
        end
    end

    // ------------------------------------------------------------------------
    // Counters and register writes
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int c = 0; c < NumTimers; c++) begin
                cnt_q[c] <= '0;
                cmp_q[c] <= '0;
            end
            enable_q <= '0;
            reload_q <= '0;
            flag_q   <= '0;
        end else begin
            for (int c = 0; c < NumTimers; c++) begin
                // A CNT write overrides counting in the same cycle
                if (wr_i && cnt_sel[c]) begin
                    cnt_q[c] <= wdata_i;
                end else if (match[c] && reload_q[c]) begin
                    cnt_q[c] <= '0;
                end else if (enable_q[c]) begin
                    cnt_q[c] <= cnt_q[c] + 1'b1;
                end

                if (wr_i && cmp_sel[c]) begin
                    cmp_q[c] <= wdata_i;
                end

                if (wr_i && ctrl_sel[c]) begin
                    enable_q[c] <= wdata_i[CtrlEnableBit];
                    reload_q[c] <= wdata_i[CtrlReloadBit];
                    flag_q[c]   <= 1'b0;
                end else if (match[c]) begin
                    flag_q[c] <= 1'b1;
                end
            end
        end
    end

    // Read mux, unknown offsets return zero
    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            for (int c = 0; c < NumTimers; c++) begin
                if (cnt_sel[c]) begin
                    rdata_o = cnt_q[c];
                end
                if (cmp_sel[c]) begin
                    rdata_o = cmp_q[c];
                end
                if (ctrl_sel[c]) begin
                    rdata_o[CtrlEnableBit] = enable_q[c];
                    rdata_o[CtrlReloadBit] = reload_q[c];
                    rdata_o[CtrlFlagBit]   = flag_q[c];
                end
            end
        end
    end

    assign flags_o = flag_q;

endmodule

/* source/irq_ctrl.sv */
// --------------------------------------------------------------------------
// Level triggered interrupt controller, four sources and one target
// Sources 0..1 are the timer flags, 2..3 the external inputs
// Priority 0 never interrupts, ties go to the lower source number
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module irq_ctrl (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               wr_i,
    input  logic                               rd_i,
    input  logic [periph_pkg::OffsetWidth-1:0] offset_i,
    input  logic [periph_pkg::DataWidth-1:0]   wdata_i,
    input  logic [periph_pkg::NumTimers-1:0]   timer_flags_i,
    input  logic [periph_pkg::NumExtIrq-1:0]   ext_irq_i,
    output logic [periph_pkg::DataWidth-1:0]   rdata_o,
    output logic                               irq_o
);
    import periph_pkg::*;

    logic [PrioWidth-1:0]  prio_q [NumSources];
    logic [NumSources-1:0] enable_q;
    logic [PrioWidth-1:0]  threshold_q;
    logic [NumSources-1:0] in_service_q;

    logic [NumSources-1:0] level;
    logic [NumSources-1:0] eligible;
    logic [SrcIdWidth-1:0] cand_id;
    logic                  claim_rd;
    logic                  complete_wr;

    assign level       = {ext_irq_i, timer_flags_i};
    assign eligible    = level & enable_q & ~in_service_q;
    assign claim_rd    = rd_i && (offset_i == OffsetWidth'(ClaimOffset));
    assign complete_wr = wr_i && (offset_i == OffsetWidth'(ClaimOffset));

    // ------------------------------------------------------------------------
    // Candidate search
    // ------------------------------------------------------------------------
    // Later hits win: higher level last, lower source last within a level
    always_comb begin
        cand_id = '0;
        for (int p = 1; p <= MaxPriority; p++) begin
            for (int s = NumSources - 1; s >= 0; s--) begin
                if (eligible[s] && int'(prio_q[s]) == p && p > int'(threshold_q)) begin
                    cand_id = SrcIdWidth'(s + 1);
                end
            end
        end
    end

    assign irq_o = (cand_id != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < NumSources; s++) begin
                prio_q[s] <= '0;
            end
            enable_q     <= '0;
            threshold_q  <= '0;
            in_service_q <= '0;
        end else begin
            for (int s = 0; s < NumSources; s++) begin
                if (wr_i && offset_i == OffsetWidth'(PrioBaseOffset + 4 * s)) begin
                    prio_q[s] <= wdata_i[PrioWidth-1:0];
                end
                // Claim marks in service, complete releases it
                if (claim_rd && cand_id == SrcIdWidth'(s + 1)) begin
                    in_service_q[s] <= 1'b1;
                end
                if (complete_wr && wdata_i == DataWidth'(s + 1)) begin
                    in_service_q[s] <= 1'b0;
                end
            end
            if (wr_i && offset_i == OffsetWidth'(EnableOffset)) begin
                enable_q <= wdata_i[NumSources-1:0];
            end
            if (wr_i && offset_i == OffsetWidth'(ThresholdOffset)) begin
                threshold_q <= wdata_i[PrioWidth-1:0];
            end
        end
    end

    // Read mux
    always_comb begin
        rdata_o = '0;
        for (int s = 0; s < NumSources; s++) begin
            if (offset_i == OffsetWidth'(PrioBaseOffset + 4 * s)) begin
                rdata_o[PrioWidth-1:0] = prio_q[s];
            end
        end
        if (offset_i == OffsetWidth'(EnableOffset)) begin
            rdata_o[NumSources-1:0] = enable_q;
        end
        if (offset_i == OffsetWidth'(ThresholdOffset)) begin
            rdata_o[PrioWidth-1:0] = threshold_q;
        end
        if (offset_i == OffsetWidth'(ClaimOffset)) begin
            rdata_o[SrcIdWidth-1:0] = cand_id;
        end
    end

endmodule

/* source/periph_top.sv */
// --------------------------------------------------------------------------
// Peripheral subsystem behind one APB style slave port
// Every access takes one cycle after the access phase, no back-pressure
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module periph_top (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             psel_i,
    input  logic                             penable_i,
    input  logic                             pwrite_i,
    input  logic [periph_pkg::AddrWidth-1:0] paddr_i,
    input  logic [periph_pkg::DataWidth-1:0] pwdata_i,
    input  logic [periph_pkg::NumExtIrq-1:0] ext_irq_i,
    output logic [periph_pkg::DataWidth-1:0] prdata_o,
    output logic                             pready_o,
    output logic                             pslverr_o,
    output logic                             irq_o
);
    import periph_pkg::*;

    logic                   wr_stb, rd_stb;
    logic [DataWidth-1:0]   rdata;
    logic                   err;
    logic [OffsetWidth-1:0] offset;
    logic [DataWidth-1:0]   wdata;
    logic                   timer_wr, timer_rd, irq_wr, irq_rd;
    logic [DataWidth-1:0]   timer_rdata, irq_rdata;
    logic [NumTimers-1:0]   timer_flags;

    apb_access_fsm i_apb_access_fsm (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .rdata_i   ( rdata     ),
        .err_i     ( err       ),
        .wr_stb_o  ( wr_stb    ),
        .rd_stb_o  ( rd_stb    ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o )
    );

    periph_decode i_periph_decode (
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .wr_stb_i      ( wr_stb      ),
        .rd_stb_i      ( rd_stb      ),
        .timer_rdata_i ( timer_rdata ),
        .irq_rdata_i   ( irq_rdata   ),
        .offset_o      ( offset      ),
        .wdata_o       ( wdata       ),
        .timer_wr_o    ( timer_wr    ),
        .timer_rd_o    ( timer_rd    ),
        .irq_wr_o      ( irq_wr      ),
        .irq_rd_o      ( irq_rd      ),
        .rdata_o       ( rdata       ),
        .err_o         ( err         )
    );

    periph_timer i_periph_timer (
        .clk_i    ( clk_i       ),
        .rst_n_i  ( rst_n_i     ),
        .wr_i     ( timer_wr    ),
        .rd_i     ( timer_rd    ),
        .offset_i ( offset      ),
        .wdata_i  ( wdata       ),
        .rdata_o  ( timer_rdata ),
        .flags_o  ( timer_flags )
    );

    irq_ctrl i_irq_ctrl (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .wr_i          ( irq_wr      ),
        .rd_i          ( irq_rd      ),
        .offset_i      ( offset      ),
        .wdata_i       ( wdata       ),
        .timer_flags_i ( timer_flags ),
        .ext_irq_i     ( ext_irq_i   ),
        .rdata_o       ( irq_rdata   ),
        .irq_o         ( irq_o       )
    );

endmodule

/* bench/periph_assert.sv */
// --------------------------------------------------------------------------
// Bus response properties, bound into every periph_top instance
// Properties are off while rst_n_i is low
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module periph_assert (
    input logic clk_i,
    input logic rst_n_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i
);
    int fail_count = 0;

    // Response lasts one cycle
    pready_one_cycle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) pready_i |=> !pready_i
    ) else begin
        $error("pready_o stayed high for more than one cycle");
        fail_count++;
    end

    pslverr_with_pready: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) pslverr_i |-> pready_i
    ) else begin
        $error("pslverr_o high without pready_o");
        fail_count++;
    end

    // Access phase seen, response at the next edge
    pready_after_access: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) $rose(psel_i && penable_i) |=> pready_i
    ) else begin
        $error("pready_o did not follow the access phase by one cycle");
        fail_count++;
    end

endmodule

bind periph_top periph_assert i_periph_assert (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pready_i  ( pready_o  ),
    .pslverr_i ( pslverr_o )
);

/* bench/tb_periph_top.sv */
// --------------------------------------------------------------------------
// Directed testbench for periph_top
// Inputs change on the rising edge and outputs are sampled on the falling edge
// Timer expectations assume one access completes before the next starts
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_periph_top;
    import periph_pkg::*;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [AddrWidth-1:0] paddr;
    logic [DataWidth-1:0] pwdata;
    logic [NumExtIrq-1:0] ext_irq;
    logic [DataWidth-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 irq;

    int edge_count  = 0;
    int strobe_edge = 0;
    int check_count = 0;
    int error_count = 0;

    always #4 clk = ~clk;

    // Rising edges since time zero for timing the timer checks
    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    periph_top i_periph_top (
        .clk_i     ( clk     ),
        .rst_n_i   ( rst_n   ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .ext_irq_i ( ext_irq ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .irq_o     ( irq     )
    );

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_data(input string name, input logic [DataWidth-1:0] got,
                              input logic [DataWidth-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR irq_o got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_claim(input logic [SrcIdWidth-1:0] got,
                               input logic [SrcIdWidth-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR prdata_o claim ID got 0x%h expected 0x%h", got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------------------
    function automatic logic [AddrWidth-1:0] timer_addr(input int ch, input int offset);
        return AddrWidth'((RegionTimer << RegionLsb) + ch * TimerStride + offset);
    endfunction

    function automatic logic [AddrWidth-1:0] irq_addr(input int offset);
        return AddrWidth'((RegionIrq << RegionLsb) + offset);
    endfunction

    // One access that records in strobe_edge the edge at which the device saw it
    task automatic bus_access(input logic write, input logic [AddrWidth-1:0] addr,
                              input logic [DataWidth-1:0] wdata,
                              output logic [DataWidth-1:0] rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        psel   <= 1'b1;
        pwrite <= write;
        paddr  <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            error_count++;
            $display("No pready_o within 16 cycles for the access to 0x%h", addr);
        end
        rdata       = prdata;
        err         = pslverr;
        strobe_edge = edge_count;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic bus_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
        logic [DataWidth-1:0] rdata;
        logic                 err;
        bus_access(1'b1, addr, data, rdata, err);
        check_resp("pslverr_o", err, 1'b0);
    endtask

    task automatic bus_read(input logic [AddrWidth-1:0] addr, output logic [DataWidth-1:0] data);
        logic err;
        bus_access(1'b0, addr, '0, data, err);
        check_resp("pslverr_o", err, 1'b0);
    endtask

    task automatic set_ext_irq(input logic [NumExtIrq-1:0] value);
        @(posedge clk);
        ext_irq <= value;
    endtask

    // Flag sets every period edges after start and a clear wins on its own edge
    function automatic bit flag_due(input int cleared, input int upto, input int start,
                                    input int period);
        int first;
        if (cleared < start + period) begin
            first = start + period;
        end else begin
            first = start + ((cleared - start) / period + 1) * period;
        end
        return first <= upto;
    endfunction

    function automatic logic [DataWidth-1:0] ctrl_word(input bit flag);
        logic [DataWidth-1:0] word;
        word                = '0;
        word[CtrlEnableBit] = 1'b1;
        word[CtrlReloadBit] = 1'b1;
        word[CtrlFlagBit]   = flag;
        return word;
    endfunction

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_round_trip();
        logic [AddrWidth-1:0] addr [2 * NumTimers + NumSources + 2];
        logic [DataWidth-1:0] mask [2 * NumTimers + NumSources + 2];
        logic [DataWidth-1:0] val  [2 * NumTimers + NumSources + 2];
        logic [DataWidth-1:0] rdata;
        for (int c = 0; c < NumTimers; c++) begin
            addr[2 * c]     = timer_addr(c, TimerCmpOffset);
            addr[2 * c + 1] = timer_addr(c, TimerCntOffset);
            mask[2 * c]     = '1;
            mask[2 * c + 1] = '1;
        end
        for (int s = 0; s < NumSources; s++) begin
            addr[2 * NumTimers + s] = irq_addr(PrioBaseOffset + 4 * s);
            mask[2 * NumTimers + s] = DataWidth'((1 << PrioWidth) - 1);
        end
        addr[2 * NumTimers + NumSources]     = irq_addr(EnableOffset);
        mask[2 * NumTimers + NumSources]     = DataWidth'((1 << NumSources) - 1);
        addr[2 * NumTimers + NumSources + 1] = irq_addr(ThresholdOffset);
        mask[2 * NumTimers + NumSources + 1] = DataWidth'((1 << PrioWidth) - 1);
        for (int i = 0; i < $size(addr); i++) begin
            val[i] = $urandom;
            bus_write(addr[i], val[i]);
        end
        for (int i = 0; i < $size(addr); i++) begin
            bus_read(addr[i], rdata);
            check_data("prdata_o", rdata, val[i] & mask[i]);
        end
    endtask

    task automatic test_empty_region();
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] rdata;
        logic [DataWidth-1:0] cmp_before;
        logic                 err;
        cmp_before = $urandom;
        bus_write(timer_addr(1, TimerCmpOffset), cmp_before);
        addr = $urandom;
        addr[RegionLsb +: RegionWidth] = RegionWidth'(2 + $urandom % 14);
        bus_access(1'b0, addr, '0, rdata, err);
        check_data("prdata_o", rdata, 32'hDEADBEEF);
        check_resp("pslverr_o", err, 1'b1);
        // Same low offset as timer 1 CMP so a leaked strobe would show
        addr[RegionLsb +: RegionWidth] = RegionWidth'(2 + $urandom % 14);
        addr[OffsetWidth-1:0] = OffsetWidth'(TimerStride + TimerCmpOffset);
        bus_access(1'b1, addr, ~cmp_before, rdata, err);
        check_resp("pslverr_o", err, 1'b1);
        bus_read(timer_addr(1, TimerCmpOffset), rdata);
        check_data("prdata_o (timer 1 CMP)", rdata, cmp_before);
    endtask

    task automatic test_timer_reload();
        logic [DataWidth-1:0] rdata;
        int                   n;
        int                   period;
        int                   start;
        int                   cleared;
        n      = 5 + int'($urandom % 36);
        period = n + 1;
        bus_write(timer_addr(0, TimerCmpOffset), DataWidth'(n));
        bus_write(timer_addr(0, TimerCntOffset), '0);
        bus_write(timer_addr(0, TimerCtrlOffset), ctrl_word(1'b0));
        start   = strobe_edge;
        cleared = strobe_edge;
        repeat (n + 6) @(posedge clk);
        // A read returns the state left by the edge before its strobe
        bus_read(timer_addr(0, TimerCtrlOffset), rdata);
        check_data("prdata_o (timer 0 CTRL)", rdata,
                   ctrl_word(flag_due(cleared, strobe_edge - 1, start, period)));
        bus_read(timer_addr(0, TimerCntOffset), rdata);
        check_data("prdata_o (timer 0 CNT)", rdata,
                   DataWidth'((strobe_edge - 1 - start) % period));
        bus_write(timer_addr(0, TimerCtrlOffset), ctrl_word(1'b0));
        cleared = strobe_edge;
        bus_read(timer_addr(0, TimerCtrlOffset), rdata);
        check_data("prdata_o (timer 0 CTRL)", rdata,
                   ctrl_word(flag_due(cleared, strobe_edge - 1, start, period)));
        repeat (period + 2) @(posedge clk);
        bus_read(timer_addr(0, TimerCtrlOffset), rdata);
        check_data("prdata_o (timer 0 CTRL)", rdata, ctrl_word(1'b1));
    endtask

    task automatic test_irq_claim();
        logic [DataWidth-1:0] rdata;
        int                   tries;
        // Source 1 is timer 1 and source 3 is ext_irq_i[1]
        bus_write(irq_addr(PrioBaseOffset + 4 * 1), 32'd2);
        bus_write(irq_addr(PrioBaseOffset + 4 * 3), 32'd5);
        bus_write(irq_addr(ThresholdOffset), 32'd1);
        bus_write(irq_addr(EnableOffset), 32'b1010);
        bus_write(timer_addr(1, TimerCmpOffset), 32'd2);
        bus_write(timer_addr(1, TimerCntOffset), 32'd0);
        bus_write(timer_addr(1, TimerCtrlOffset), 32'd1);
        set_ext_irq(2'b10);
        tries = 0;
        rdata = '0;
        while (!rdata[CtrlFlagBit] && tries < 8) begin
            bus_read(timer_addr(1, TimerCtrlOffset), rdata);
            tries++;
        end
        if (!rdata[CtrlFlagBit]) begin
            error_count++;
            $display("Timer 1 flag did not set after %0d reads", tries);
        end
        @(negedge clk);
        check_irq(irq, 1'b1);
        bus_read(irq_addr(ClaimOffset), rdata);
        check_claim(rdata[SrcIdWidth-1:0], 3'd4);
        bus_read(irq_addr(ClaimOffset), rdata);
        check_claim(rdata[SrcIdWidth-1:0], 3'd2);
        bus_read(irq_addr(ClaimOffset), rdata);
        check_claim(rdata[SrcIdWidth-1:0], 3'd0);
        @(negedge clk);
        check_irq(irq, 1'b0);
        bus_write(irq_addr(ClaimOffset), 32'd4);
        bus_write(irq_addr(ClaimOffset), 32'd2);
        @(negedge clk);
        check_irq(irq, 1'b1);
    endtask

    task automatic test_threshold_tie();
        logic [DataWidth-1:0] rdata;
        bus_write(irq_addr(PrioBaseOffset + 4 * 2), 32'd4);
        bus_write(irq_addr(PrioBaseOffset + 4 * 3), 32'd4);
        bus_write(irq_addr(ThresholdOffset), 32'd0);
        bus_write(irq_addr(EnableOffset), 32'b1100);
        set_ext_irq(2'b11);
        bus_read(irq_addr(ClaimOffset), rdata);
        check_claim(rdata[SrcIdWidth-1:0], 3'd3);
        @(negedge clk);
        check_irq(irq, 1'b1);
        bus_write(irq_addr(ThresholdOffset), 32'd4);
        @(negedge clk);
        check_irq(irq, 1'b0);
        bus_read(irq_addr(ClaimOffset), rdata);
        check_claim(rdata[SrcIdWidth-1:0], 3'd0);
        bus_write(irq_addr(ClaimOffset), 32'd3);
        set_ext_irq(2'b00);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        int total_errors;
        void'($urandom(32'h39754a88));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        ext_irq = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_resp("pready_o", pready, 1'b0);
        check_resp("pslverr_o", pslverr, 1'b0);
        check_irq(irq, 1'b0);
        test_round_trip();
        test_empty_region();
        test_timer_reload();
        test_irq_claim();
        test_threshold_tie();
        repeat (4) @(posedge clk);
        total_errors = error_count + i_periph_top.i_periph_assert.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count,
                 error_count, i_periph_top.i_periph_assert.fail_count);
        if (total_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Cycle budgets per test plus reset and margin
    initial begin
        int budget;
        budget = 8 + 150 + 40 + 170 + 140 + 90 + 200;
        repeat (budget) @(posedge clk);
        $display("Watchdog expired after %0d cycles", budget);
        $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* all.f */
source/periph_pkg.sv
source/apb_access_fsm.sv
source/periph_decode.sv
source/periph_timer.sv
source/irq_ctrl.sv
source/periph_top.sv
bench/periph_assert.sv
bench/tb_periph_top.sv

/* run.sh */
#!/bin/sh
# Build and run the periph_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_periph_top -f all.f \
    && ./obj_dir/Vtb_periph_top +verilator+error+limit+100 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0
